/* build.f */
common/rv32i_types.sv
common/tomasulo_types.sv
reservation_station/br_rs.sv
hdl/br_unit.sv
hdl/br_core.sv
verification/br_core_assert.sv
verification/br_core_tb.sv

/* common/rv32i_types.sv */
`default_nettype none

// rv32i encodings and widths used by the branch path
package rv32i_types;

	// architectural word width
	localparam int xlen = 32;

	// data and address word
	typedef logic [xlen-1:0] word_t;

	// fall-through step, all instructions are 4 bytes
	localparam word_t pc_step = 32'd4;

	// funct3 field width of the b-type format
	localparam int funct3_w = 3;

	// branch condition codes as found in funct3
	// 3'b010 and 3'b011 are unused by the branch opcode
	typedef enum logic [funct3_w-1:0] {
		beq  = 3'b000,
		bne  = 3'b001,
		blt  = 3'b100,
		bge  = 3'b101,
		bltu = 3'b110,
		bgeu = 3'b111
	} br_funct3_t;

	// funct3[2] picks the ordered compares, funct3[1] the unsigned ones
	// funct3[0] inverts the condition, kept here as a reminder only
	// br_unit decodes the full enum instead of these bits

endpackage : rv32i_types

`default_nettype wire

/* common/tomasulo_types.sv */
`default_nettype none

// bookkeeping types of the out-of-order core
package tomasulo_types;

	import rv32i_types::*;

	// rob tag width, 16 instructions in flight at most
	localparam int rob_tag_w = 4;

	// identifies an instruction by its rob slot
	typedef logic [rob_tag_w-1:0] rob_tag_t;

	// an operand slot is a busy flag next to a word_t
	// busy set: the low bits of the word name the producer
	// busy clear: the word is the operand value itself

	// producer tag held in a busy operand slot
	function automatic rob_tag_t slot_tag(input word_t slot);
		return slot[rob_tag_w-1:0];
	endfunction

	// true when a busy slot waits on the tag now on the cdb
	function automatic logic slot_wakes(
		input logic   busy,
		input word_t  slot,
		input logic   cdb_valid,
		input rob_tag_t cdb_tag
	);
		return busy && cdb_valid && (slot_tag(slot) == cdb_tag);
	endfunction

endpackage : tomasulo_types

`default_nettype wire

/* hdl/br_core.sv */
`timescale 1ns/1ps
`default_nettype none

module br_core
	import rv32i_types::*, tomasulo_types::*;
#(
	parameter int rs_depth = 4
)
(
	input  logic       clk,
	input  logic       reset,
	input  logic       flush,

	// issue
	input  logic       issue_valid,
	input  br_funct3_t issue_funct3,
	input  word_t      issue_pc,
	input  word_t      issue_imm,
	input  logic       issue_pred_taken,
	input  rob_tag_t   issue_tag,
	input  logic       issue_busy_a,
	input  logic       issue_busy_b,
	input  word_t      issue_a,
	input  word_t      issue_b,
	output logic       issue_ready,

	// common data bus
	input  logic       cdb_valid,
	input  rob_tag_t   cdb_tag,
	input  word_t      cdb_value,

	// result
	output logic       res_valid,
	output rob_tag_t   res_tag,
	output logic       res_taken,
	output word_t      res_next_pc,
	output logic       res_mispredict
);

	// dispatch path between station and unit
	logic       disp_valid;
	br_funct3_t disp_funct3;
	word_t      disp_a;
	word_t      disp_b;
	word_t      disp_pc;
	word_t      disp_imm;
	logic       disp_pred_taken;
	rob_tag_t   disp_tag;

	br_rs #(
		.rs_depth(rs_depth)
	) rs_inst (
		.clk              (clk),
		.reset            (reset),
		.flush            (flush),
		.issue_valid      (issue_valid),
		.issue_funct3     (issue_funct3),
		.issue_pc         (issue_pc),
		.issue_imm        (issue_imm),
		.issue_pred_taken (issue_pred_taken),
		.issue_tag        (issue_tag),
		.issue_busy_a     (issue_busy_a),
		.issue_busy_b     (issue_busy_b),
		.issue_a          (issue_a),
		.issue_b          (issue_b),
		.issue_ready      (issue_ready),
		.cdb_valid        (cdb_valid),
		.cdb_tag          (cdb_tag),
		.cdb_value        (cdb_value),
		.disp_valid       (disp_valid),
		.disp_funct3      (disp_funct3),
		.disp_a           (disp_a),
		.disp_b           (disp_b),
		.disp_pc          (disp_pc),
		.disp_imm         (disp_imm),
		.disp_pred_taken  (disp_pred_taken),
		.disp_tag         (disp_tag)
	);

	br_unit unit_inst (
		.clk              (clk),
		.reset            (reset),
		.flush            (flush),
		.disp_valid       (disp_valid),
		.disp_funct3      (disp_funct3),
		.disp_a           (disp_a),
		.disp_b           (disp_b),
		.disp_pc          (disp_pc),
		.disp_imm         (disp_imm),
		.disp_pred_taken  (disp_pred_taken),
		.disp_tag         (disp_tag),
		.res_valid        (res_valid),
		.res_tag          (res_tag),
		.res_taken        (res_taken),
		.res_next_pc      (res_next_pc),
		.res_mispredict   (res_mispredict)
	);

endmodule : br_core

`default_nettype wire

/* hdl/br_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module br_unit
	import rv32i_types::*, tomasulo_types::*;
(
	input  logic       clk,
	input  logic       reset,
	input  logic       flush,

	// from the station, always accepted
	input  logic       disp_valid,
	input  br_funct3_t disp_funct3,
	input  word_t      disp_a,
	input  word_t      disp_b,
	input  word_t      disp_pc,
	input  word_t      disp_imm,
	input  logic       disp_pred_taken,
	input  rob_tag_t   disp_tag,

	// resolved branch
	output logic       res_valid,
	output rob_tag_t   res_tag,
	output logic       res_taken,
	output word_t      res_next_pc,
	output logic       res_mispredict
);

	// compare results
	logic  cmp_eq;
	logic  cmp_lt;
	logic  cmp_ltu;
	logic  taken;
	word_t next_pc;

	assign cmp_eq  = (disp_a == disp_b);
	assign cmp_lt  = ($signed(disp_a) < $signed(disp_b));
	assign cmp_ltu = (disp_a < disp_b);

	// condition per funct3
	always_comb
	begin
		case (disp_funct3)
			beq:     taken = cmp_eq;
			bne:     taken = !cmp_eq;
			blt:     taken = cmp_lt;
			bge:     taken = !cmp_lt;
			bltu:    taken = cmp_ltu;
			bgeu:    taken = !cmp_ltu;
			default: taken = 1'b0;
		endcase
	end

	// target or fall-through
	assign next_pc = taken ? (disp_pc + disp_imm) : (disp_pc + pc_step);

	always_ff @(posedge clk)
	begin
		if (reset || flush)
			res_valid <= 1'b0;
		else
			res_valid <= disp_valid;

		if (disp_valid)
		begin
			res_tag        <= disp_tag;
			res_taken      <= taken;
			res_next_pc    <= next_pc;
			// wrong direction guessed at fetch
			res_mispredict <= (taken != disp_pred_taken);
		end
	end

endmodule : br_unit

`default_nettype wire

/* reservation_station/br_rs.sv */
`timescale 1ns/1ps
`default_nettype none

module br_rs
	import rv32i_types::*, tomasulo_types::*;
#(
	parameter int rs_depth = 4
)
(
	input  logic       clk,
	input  logic       reset,
	input  logic       flush,

	// issue side
	input  logic       issue_valid,
	input  br_funct3_t issue_funct3,
	input  word_t      issue_pc,
	input  word_t      issue_imm,
	input  logic       issue_pred_taken,
	input  rob_tag_t   issue_tag,
	input  logic       issue_busy_a,
	input  logic       issue_busy_b,
	input  word_t      issue_a,
	input  word_t      issue_b,
	output logic       issue_ready,

	// common data bus
	input  logic       cdb_valid,
	input  rob_tag_t   cdb_tag,
	input  word_t      cdb_value,

	// towards the branch unit
	output logic       disp_valid,
	output br_funct3_t disp_funct3,
	output word_t      disp_a,
	output word_t      disp_b,
	output word_t      disp_pc,
	output word_t      disp_imm,
	output logic       disp_pred_taken,
	output rob_tag_t   disp_tag
);

	// entry index and free count widths
	localparam int idx_w = $clog2(rs_depth);
	localparam int cnt_w = $clog2(rs_depth) + 1;

	// entry control
	logic [rs_depth-1:0] ent_valid;
	logic [rs_depth-1:0] ent_busy_a;
	logic [rs_depth-1:0] ent_busy_b;

	// entry payload
	word_t      ent_a        [rs_depth];
	word_t      ent_b        [rs_depth];
	word_t      ent_pc       [rs_depth];
	word_t      ent_imm      [rs_depth];
	br_funct3_t ent_funct3   [rs_depth];
	logic       ent_pred     [rs_depth];
	rob_tag_t   ent_tag      [rs_depth];

	// selection
	logic [rs_depth-1:0] ent_ready;
	logic [rs_depth-1:0] ent_free;
	logic [rs_depth-1:0] disp_onehot;
	logic [rs_depth-1:0] issue_onehot;
	logic [idx_w-1:0]    disp_sel;
	logic [idx_w-1:0]    issue_sel;
	logic                disp_hit;
	logic [cnt_w-1:0]    free_count;

	// issue side
	logic issue_fire;
	logic issue_wake_a;
	logic issue_wake_b;

	// ready means valid with both operands holding values
	assign ent_ready = ent_valid & ~ent_busy_a & ~ent_busy_b;

	// oldest-first is not tracked, lowest index wins
	always_comb
	begin
		disp_hit    = 1'b0;
		disp_sel    = '0;
		disp_onehot = '0;
		for (int i = 0; i < rs_depth; i++)
		begin
			if (ent_ready[i] && !disp_hit)
			begin
				disp_hit       = 1'b1;
				disp_sel       = idx_w'(i);
				disp_onehot[i] = 1'b1;
			end
		end
	end

	// an entry leaving this cycle can be refilled at the same edge
	assign ent_free = ~ent_valid | disp_onehot;

	// lowest free slot and number of free slots
	always_comb
	begin
		issue_sel    = '0;
		issue_onehot = '0;
		free_count   = '0;
		for (int i = 0; i < rs_depth; i++)
		begin
			if (ent_free[i])
			begin
				if (free_count == '0)
				begin
					issue_sel       = idx_w'(i);
					issue_onehot[i] = 1'b1;
				end
				free_count = free_count + cnt_w'(1);
			end
		end
	end

	assign issue_ready = (free_count != '0);
	assign issue_fire  = issue_valid && issue_ready;

	// catch a broadcast in the same cycle as the issue
	assign issue_wake_a = slot_wakes(issue_busy_a, issue_a, cdb_valid, cdb_tag);
	assign issue_wake_b = slot_wakes(issue_busy_b, issue_b, cdb_valid, cdb_tag);

	// operand slots and branch fields
	always_ff @(posedge clk)
	begin
		// wake-up from the cdb
		for (int i = 0; i < rs_depth; i++)
		begin
			if (ent_valid[i] && slot_wakes(ent_busy_a[i], ent_a[i], cdb_valid, cdb_tag))
			begin
				ent_a[i]      <= cdb_value;
				ent_busy_a[i] <= 1'b0;
			end
			if (ent_valid[i] && slot_wakes(ent_busy_b[i], ent_b[i], cdb_valid, cdb_tag))
			begin
				ent_b[i]      <= cdb_value;
				ent_busy_b[i] <= 1'b0;
			end
		end

		// capture, written last so a refilled slot takes the new branch
		if (issue_fire)
		begin
			ent_funct3[issue_sel] <= issue_funct3;
			ent_pc[issue_sel]     <= issue_pc;
			ent_imm[issue_sel]    <= issue_imm;
			ent_pred[issue_sel]   <= issue_pred_taken;
			ent_tag[issue_sel]    <= issue_tag;
			ent_busy_a[issue_sel] <= issue_busy_a && !issue_wake_a;
			ent_busy_b[issue_sel] <= issue_busy_b && !issue_wake_b;
			ent_a[issue_sel]      <= issue_wake_a ? cdb_value : issue_a;
			ent_b[issue_sel]      <= issue_wake_b ? cdb_value : issue_b;
		end

		// dispatch payload
		if (disp_hit)
		begin
			disp_funct3     <= ent_funct3[disp_sel];
			disp_a          <= ent_a[disp_sel];
			disp_b          <= ent_b[disp_sel];
			disp_pc         <= ent_pc[disp_sel];
			disp_imm        <= ent_imm[disp_sel];
			disp_pred_taken <= ent_pred[disp_sel];
			disp_tag        <= ent_tag[disp_sel];
		end
	end

	// occupancy and dispatch strobe
	always_ff @(posedge clk)
	begin
		if (reset || flush)
		begin
			// a flush also squashes the issue and dispatch of this cycle
			ent_valid  <= '0;
			disp_valid <= 1'b0;
		end
		else
		begin
			disp_valid <= disp_hit;
			ent_valid  <= (ent_valid & ~disp_onehot) | (issue_fire ? issue_onehot : '0);
		end
	end

endmodule : br_rs

`default_nettype wire

/* run.sh */
#!/bin/sh
# compile and run the br_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module br_core_tb -f build.f -o sim_br_core

out=$(./obj_dir/sim_br_core)
echo "$out"

if echo "$out" | grep -qx "No errors"; then
	exit 0
else
	exit 1
fi

/* verification/br_core_assert.sv */
`timescale 1ns/1ps
`default_nettype none

// protocol checks on the dispatch and result path of br_core
module br_core_assert
(
	input wire logic clk,
	input wire logic reset,
	input wire logic flush,
	input wire logic disp_valid,
	input wire logic res_valid,
	input wire logic issue_ready
);

	// the branch unit is one stage, a dispatch gives a result next cycle
	res_after_disp: assert property (
		@(posedge clk) disable iff (reset || flush)
		disp_valid |=> res_valid
	)
	else
		$error("res_valid missing one cycle after disp_valid");

	// and no result appears without a dispatch before it
	no_res_without_disp: assert property (
		@(posedge clk) disable iff (reset || flush)
		!disp_valid |=> !res_valid
	)
	else
		$error("res_valid without a dispatch in the previous cycle");

	// an empty station always has room
	ready_after_reset: assert property (
		@(posedge clk)
		reset |=> issue_ready
	)
	else
		$error("issue_ready low after reset");

	// flush squashes the dispatch of its own cycle
	no_disp_after_flush: assert property (
		@(posedge clk)
		flush |=> !disp_valid
	)
	else
		$error("dispatch in the cycle after a flush");

endmodule : br_core_assert

`default_nettype wire

/* verification/br_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module br_core_tb
	import rv32i_types::*, tomasulo_types::*;
();

	// tests take a few hundred cycles at most, this leaves a wide margin
	localparam int cycle_limit = 2000;

	logic clk;
	logic reset;
	logic flush;
	logic issue_valid;
	br_funct3_t issue_funct3;
	word_t issue_pc;
	word_t issue_imm;
	logic issue_pred_taken;
	rob_tag_t issue_tag;
	logic issue_busy_a;
	logic issue_busy_b;
	word_t issue_a;
	word_t issue_b;
	logic issue_ready;
	logic cdb_valid;
	rob_tag_t cdb_tag;
	word_t cdb_value;
	logic res_valid;
	rob_tag_t res_tag;
	logic res_taken;
	word_t res_next_pc;
	logic res_mispredict;

	// scoreboard, indexed by rob tag
	logic outstanding [16];
	logic [33:0] exp_res [16];
	logic wait_a [16];
	logic wait_b [16];
	rob_tag_t src_a_of [16];
	rob_tag_t src_b_of [16];
	// value each producer tag puts on the cdb
	word_t prod_val [16];
	rob_tag_t res_order [$];
	int open_count = 0;
	int errors = 0;
	int results_seen = 0;
	int test_no = 0;
	int errors_base = 0;
	int seed = 32'h8d2f4fac;
	logic ready_seen;

	// branch waiting to be accepted
	logic [33:0] pend_exp;
	logic pend_busy_a;
	logic pend_busy_b;
	rob_tag_t pend_src_a;
	rob_tag_t pend_src_b;

	br_funct3_t funct3_list [6] = '{beq, bne, blt, bge, bltu, bgeu};
	// equal, less, greater, two sign boundaries, one random slot
	word_t pair_a [6] = '{32'd5, 32'd3, 32'd7, 32'h8000_0000, 32'hffff_ffff, 32'd0};
	word_t pair_b [6] = '{32'd5, 32'd7, 32'd3, 32'h7fff_ffff, 32'h0000_0000, 32'd0};

	br_core #(
		.rs_depth(4)
	) br_core_inst (
		.clk              (clk),
		.reset            (reset),
		.flush            (flush),
		.issue_valid      (issue_valid),
		.issue_funct3     (issue_funct3),
		.issue_pc         (issue_pc),
		.issue_imm        (issue_imm),
		.issue_pred_taken (issue_pred_taken),
		.issue_tag        (issue_tag),
		.issue_busy_a     (issue_busy_a),
		.issue_busy_b     (issue_busy_b),
		.issue_a          (issue_a),
		.issue_b          (issue_b),
		.issue_ready      (issue_ready),
		.cdb_valid        (cdb_valid),
		.cdb_tag          (cdb_tag),
		.cdb_value        (cdb_value),
		.res_valid        (res_valid),
		.res_tag          (res_tag),
		.res_taken        (res_taken),
		.res_next_pc      (res_next_pc),
		.res_mispredict   (res_mispredict)
	);

	bind br_core br_core_assert assert_inst (
		.clk         (clk),
		.reset       (reset),
		.flush       (flush),
		.disp_valid  (disp_valid),
		.res_valid   (res_valid),
		.issue_ready (issue_ready)
	);

	// expected {taken, mispredict, next pc} from the rv32i branch rules
	function automatic logic [33:0] ref_branch(input br_funct3_t f, input word_t a,
		input word_t b, input word_t pc, input word_t imm, input logic pred);
		logic taken;
		word_t npc;
		case (f)
			beq:     taken = (a == b);
			bne:     taken = (a != b);
			blt:     taken = ($signed(a) < $signed(b));
			bge:     taken = ($signed(a) >= $signed(b));
			bltu:    taken = (a < b);
			bgeu:    taken = (a >= b);
			default: taken = 1'b0;
		endcase
		npc = taken ? (pc + imm) : (pc + 32'd4);
		return {taken, taken != pred, npc};
	endfunction

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// put a branch on the issue port, busy operands carry the producer tag
	task automatic start_issue(input rob_tag_t tag, input br_funct3_t f, input word_t a,
		input word_t b, input logic busy_a, input rob_tag_t src_a, input logic busy_b,
		input rob_tag_t src_b);
		word_t pc;
		word_t imm_raw;
		word_t imm;
		pc = $random(seed) & 32'hffff_fffc;
		imm_raw = $random(seed);
		// b-type immediate is 13 bits signed and even
		imm = {{19{imm_raw[12]}}, imm_raw[12:1], 1'b0};
		issue_valid = 1'b1;
		issue_tag = tag;
		issue_funct3 = f;
		issue_pc = pc;
		issue_imm = imm;
		issue_pred_taken = imm_raw[20];
		issue_busy_a = busy_a;
		issue_busy_b = busy_b;
		issue_a = busy_a ? word_t'(src_a) : a;
		issue_b = busy_b ? word_t'(src_b) : b;
		if (busy_a)
			prod_val[src_a] = a;
		if (busy_b)
			prod_val[src_b] = b;
		pend_exp = ref_branch(f, a, b, pc, imm, imm_raw[20]);
		pend_busy_a = busy_a;
		pend_busy_b = busy_b;
		pend_src_a = src_a;
		pend_src_b = src_b;
	endtask

	// broadcast a producer for one cycle
	task automatic set_cdb(input rob_tag_t tag);
		cdb_valid = 1'b1;
		cdb_tag = tag;
		cdb_value = prod_val[tag];
	endtask

	// one clock, handshake sampled at the falling edge
	// scoreboard updated at the rising edge where the dut takes issue and cdb
	task automatic tick();
		logic accepted;
		@(negedge clk);
		accepted = issue_valid && issue_ready && !flush;
		ready_seen = issue_ready;
		@(posedge clk);
		if (accepted)
		begin
			outstanding[issue_tag] = 1'b1;
			exp_res[issue_tag] = pend_exp;
			wait_a[issue_tag] = pend_busy_a;
			wait_b[issue_tag] = pend_busy_b;
			src_a_of[issue_tag] = pend_src_a;
			src_b_of[issue_tag] = pend_src_b;
			open_count++;
		end
		// a broadcast in the issue cycle also clears the new entry
		if (cdb_valid)
		begin
			for (int i = 0; i < 16; i++)
			begin
				if (wait_a[i] && src_a_of[i] == cdb_tag)
					wait_a[i] = 1'b0;
				if (wait_b[i] && src_b_of[i] == cdb_tag)
					wait_b[i] = 1'b0;
			end
		end
		#2;
		if (accepted)
			issue_valid = 1'b0;
		cdb_valid = 1'b0;
	endtask

	task automatic wait_accept();
		tick();
		while (issue_valid)
			tick();
	endtask

	task automatic issue_wait(input rob_tag_t tag, input br_funct3_t f, input word_t a,
		input word_t b, input logic busy_a, input rob_tag_t src_a, input logic busy_b,
		input rob_tag_t src_b);
		start_issue(tag, f, a, b, busy_a, src_a, busy_b, src_b);
		wait_accept();
	endtask

	// wait for every outstanding result, the cycle limit catches a hang
	task automatic drain();
		while (open_count != 0)
			tick();
		tick();
	endtask

	task automatic end_test(input string name);
		test_no++;
		$display("test %0d %s finished, %0d failed checks", test_no, name, errors - errors_base);
		errors_base = errors;
	endtask

	// comparing process
	always @(negedge clk)
	begin
		rob_tag_t t;
		t = res_tag;
		if (!reset && res_valid)
		begin
			results_seen++;
			res_order.push_back(t);
			assert (outstanding[t])
			else
			begin
				$display("result for rob tag %0d at %0t was never issued or already seen", t, $time);
				errors++;
			end
			if (outstanding[t])
			begin
				assert (!wait_a[t] && !wait_b[t])
				else
				begin
					$display("result for rob tag %0d came before its operand broadcast", t);
					errors++;
				end
				assert ({res_taken, res_mispredict, res_next_pc} == exp_res[t])
				else
				begin
					$display("FAILED at %0t: tag %0d got taken %b mispredict %b pc %h, expected %h",
						$time, t, res_taken, res_mispredict, res_next_pc, exp_res[t]);
					errors++;
				end
				outstanding[t] = 1'b0;
				open_count--;
			end
		end
	end

	// cycle counter against a hang
	initial
	begin
		int cycles;
		cycles = 0;
		while (cycles < cycle_limit)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, %0d results still missing", cycles, open_count);
		$display("Errors found");
		$finish;
	end

	initial
	begin
		rob_tag_t pend [$];
		int idx;
		for (int i = 0; i < 16; i++)
		begin
			outstanding[i] = 1'b0;
			wait_a[i] = 1'b0;
			wait_b[i] = 1'b0;
			prod_val[i] = '0;
		end
		reset = 1'b1;
		flush = 1'b0;
		issue_valid = 1'b0;
		issue_funct3 = beq;
		issue_pc = '0;
		issue_imm = '0;
		issue_pred_taken = 1'b0;
		issue_tag = '0;
		issue_busy_a = 1'b0;
		issue_busy_b = 1'b0;
		issue_a = '0;
		issue_b = '0;
		cdb_valid = 1'b0;
		cdb_tag = '0;
		cdb_value = '0;
		repeat (4) @(posedge clk);
		#2;
		reset = 1'b0;

		// six conditions over the fixed operand pairs, ready at issue
		pair_a[5] = $random(seed);
		pair_b[5] = $random(seed);
		for (int f = 0; f < 6; f++)
		begin
			for (int p = 0; p < 6; p++)
				issue_wait(rob_tag_t'(p), funct3_list[f], pair_a[p], pair_b[p], 1'b0,
					'0, 1'b0, '0);
			drain();
		end
		end_test("conditions");

		// wake-up, producers 8 to 15, one broadcast in the issue cycle
		for (int i = 0; i < 4; i++)
		begin
			idx = $unsigned($random(seed)) % 6;
			pair_a[0] = $random(seed);
			pair_b[0] = (i == 1) ? pair_a[0] : $random(seed);
			start_issue(rob_tag_t'(i), funct3_list[idx], pair_a[0], pair_b[0], 1'b1,
				rob_tag_t'(8 + 2 * i), i != 2, rob_tag_t'(9 + 2 * i));
			if (i == 3)
				set_cdb(rob_tag_t'(14));
			else
				pend.push_back(rob_tag_t'(8 + 2 * i));
			if (i != 2)
				pend.push_back(rob_tag_t'(9 + 2 * i));
			wait_accept();
		end
		// remaining producers in random order
		while (pend.size() != 0)
		begin
			idx = $unsigned($random(seed)) % pend.size();
			set_cdb(pend[idx]);
			pend.delete(idx);
			tick();
		end
		drain();
		end_test("wake-up");

		// older branch waits, younger one is ready
		res_order.delete();
		issue_wait(4'd1, blt, -32'sd5, 32'd9, 1'b1, 4'd12, 1'b0, '0);
		issue_wait(4'd2, bgeu, $random(seed), $random(seed), 1'b0, '0, 1'b0, '0);
		repeat (4) tick();
		set_cdb(4'd12);
		tick();
		drain();
		assert (res_order.size() == 2 && res_order[0] == 4'd2 && res_order[1] == 4'd1)
		else
		begin
			$display("younger ready branch did not complete ahead of the waiting one");
			errors++;
		end
		end_test("out-of-order");

		// fill all four entries, the fifth branch must be held
		for (int i = 0; i < 4; i++)
			issue_wait(rob_tag_t'(i), funct3_list[i], $random(seed), $random(seed), 1'b1,
				rob_tag_t'(8 + i), 1'b0, '0);
		start_issue(4'd4, bne, $random(seed), $random(seed), 1'b0, '0, 1'b0, '0);
		repeat (2) tick();
		assert (!ready_seen && issue_valid)
		else
		begin
			$display("issue_ready stayed high with every entry taken");
			errors++;
		end
		set_cdb(4'd10);
		wait_accept();
		set_cdb(4'd8);
		tick();
		set_cdb(4'd9);
		tick();
		set_cdb(4'd11);
		tick();
		drain();
		end_test("back-pressure");

		// pending branches are dropped by the flush
		for (int i = 4; i < 7; i++)
			issue_wait(rob_tag_t'(i), funct3_list[i - 4], $random(seed), $random(seed), 1'b1,
				rob_tag_t'(8 + i), 1'b0, '0);
		// one ready branch sits in the unit, the next is in dispatch at the flush
		issue_wait(4'd15, beq, $random(seed), $random(seed), 1'b0, '0, 1'b0, '0);
		issue_wait(4'd10, bltu, $random(seed), $random(seed), 1'b0, '0, 1'b0, '0);
		flush = 1'b1;
		tick();
		flush = 1'b0;
		for (int i = 0; i < 16; i++)
			outstanding[i] = 1'b0;
		open_count = 0;
		tick();
		assert (ready_seen)
		else
		begin
			$display("issue_ready low after the flush");
			errors++;
		end
		// late broadcasts must not revive a flushed branch
		for (int i = 12; i < 15; i++)
		begin
			set_cdb(rob_tag_t'(i));
			tick();
		end
		repeat (4) tick();
		for (int i = 7; i < 10; i++)
			issue_wait(rob_tag_t'(i), funct3_list[i - 4], $random(seed), $random(seed), 1'b0,
				'0, 1'b0, '0);
		drain();
		end_test("flush");

		$display("results checked %0d, failed checks %0d", results_seen, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule : br_core_tb

`default_nettype wire
